//--- common/ctrlPkg.sv
package ctrlPkg;

	// ALU operation codes
	typedef enum logic [3:0] {
		aluAnd  = 4'b0000,
		aluXor  = 4'b0001,
		aluSub  = 4'b0010,
		aluAdd  = 4'b0100,
		aluSubU = 4'b1001,
		aluOr   = 4'b1100,
		aluMov  = 4'b1101
	} aluOpT;

	typedef enum logic [1:0] {
		ext5  = 2'b00,
		ext12 = 2'b01,
		ext20 = 2'b10
	} immSrcT;

	typedef enum logic [1:0] {
		shLsl = 2'b00,
		shLsr = 2'b01,
		shAsr = 2'b10,
		shRr  = 2'b11
	} shiftOpT;

	typedef enum logic [2:0] {
		resAlu     = 3'b000,
		resMem     = 3'b001,
		resShift   = 3'b010,
		resSlt     = 3'b011,
		resPcPlus4 = 3'b100,
		resPcImm   = 3'b101,
		resImm     = 3'b110
	} resultSrcT;

	typedef enum logic [2:0] {
		memW  = 3'b000,
		memHu = 3'b001,
		memH  = 3'b010,
		memBu = 3'b011,
		memB  = 3'b100
	} memOpT;

	// Nine kinds, so four bits
	typedef enum logic [3:0] {
		brNone = 4'd0,
		brEq   = 4'd1,
		brNe   = 4'd2,
		brLt   = 4'd3,
		brGe   = 4'd4,
		brLtu  = 4'd5,
		brGeu  = 4'd6,
		brJal  = 4'd7,
		brJalr = 4'd8
	} branchOpT;

	typedef enum logic [1:0] {
		pcPlus4     = 2'd0,
		pcTarget    = 2'd1,
		pcAluResult = 2'd2
	} pcSrcT;

	typedef struct packed {
		logic      regWrite;
		logic      memWrite;
		logic      aluSrc;
		logic      immSelect;
		logic      shamtSelect;
		immSrcT    immSrc;
		shiftOpT   shiftOp;
		resultSrcT resultSrc;
		memOpT     memOp;
		aluOpT     aluOp;
		branchOpT  branchOp;
		logic [19:0] imm;
	} ctrlT;

	localparam ctrlT ctrlIdle = '{
		regWrite: 1'b0, memWrite: 1'b0, aluSrc: 1'b0, immSelect: 1'b0,
		shamtSelect: 1'b0, immSrc: ext5, shiftOp: shLsl, resultSrc: resAlu,
		memOp: memW, aluOp: aluMov, branchOp: brNone, imm: 20'b0
	};

	// Major opcodes
	localparam logic [6:0] opLoad   = 7'b0000011;
	localparam logic [6:0] opImm    = 7'b0010011;
	localparam logic [6:0] opAuipc  = 7'b0010111;
	localparam logic [6:0] opStore  = 7'b0100011;
	localparam logic [6:0] opOp     = 7'b0110011;
	localparam logic [6:0] opLui    = 7'b0110111;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opJalr   = 7'b1100111;
	localparam logic [6:0] opJal    = 7'b1101111;

	localparam logic [6:0] f7Base = 7'b0000000;
	localparam logic [6:0] f7Alt  = 7'b0100000; // sub and sra

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rFmtT;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} iFmtT;

	typedef struct packed {
		logic [6:0] immHi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] immLo;
		logic [6:0] opcode;
	} sFmtT;

	typedef struct packed {
		logic       immSign;  // imm[12]
		logic [5:0] immHi;    // imm[10:5]
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] immLo;    // imm[4:1]
		logic       immBit11;
		logic [6:0] opcode;
	} bFmtT;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} uFmtT;

	typedef struct packed {
		logic       immSign;  // imm[20]
		logic [9:0] immLo;    // imm[10:1]
		logic       immBit11;
		logic [7:0] immHi;    // imm[19:12]
		logic [4:0] rd;
		logic [6:0] opcode;
	} jFmtT;

	typedef union packed {
		rFmtT rFmt;
		iFmtT iFmt;
		sFmtT sFmt;
		bFmtT bFmt;
		uFmtT uFmt;
		jFmtT jFmt;
	} instrU;

endpackage

//--- decoder/opDecoder.sv
`timescale 1ns/1ps

module opDecoder (
	input  ctrlPkg::instrU instr,
	output ctrlPkg::ctrlT  dec
);
	import ctrlPkg::*;

	logic [6:0] opcode;
	logic [6:0] funct7;
	logic [2:0] funct3;
	logic       legal;

	assign opcode = instr.rFmt.opcode;
	assign funct7 = instr.rFmt.funct7;
	assign funct3 = instr.rFmt.funct3;

	always_comb begin
		dec = ctrlIdle;
		legal = 1'b1;
		case (opcode)
			opOp: begin
				dec.regWrite = 1'b1;
				case ({funct7, funct3})
					{f7Base, 3'b000}: dec.aluOp = aluAdd;
					{f7Alt, 3'b000}: dec.aluOp = aluSub;
					{f7Base, 3'b111}: dec.aluOp = aluAnd;
					{f7Base, 3'b110}: dec.aluOp = aluOr;
					{f7Base, 3'b100}: dec.aluOp = aluXor;
					{f7Base, 3'b001}: begin
						dec.resultSrc = resShift;
						dec.shamtSelect = 1'b1; // Amount from rs2
						dec.shiftOp = shLsl;
					end
					{f7Base, 3'b101}: begin
						dec.resultSrc = resShift;
						dec.shamtSelect = 1'b1;
						dec.shiftOp = shLsr;
					end
					{f7Alt, 3'b101}: begin
						dec.resultSrc = resShift;
						dec.shamtSelect = 1'b1;
						dec.shiftOp = shAsr;
					end
					{f7Base, 3'b010}: begin
						dec.aluOp = aluSub;
						dec.resultSrc = resSlt;
					end
					{f7Base, 3'b011}: begin
						dec.aluOp = aluSubU;
						dec.resultSrc = resSlt;
					end
					default: legal = 1'b0;
				endcase
			end
			opImm: begin
				dec.regWrite = 1'b1;
				dec.aluSrc = 1'b1;
				dec.immSrc = ext12;
				case (funct3)
					3'b000: dec.aluOp = aluAdd;
					3'b111: dec.aluOp = aluAnd;
					3'b110: dec.aluOp = aluOr;
					3'b100: dec.aluOp = aluXor;
					3'b010: begin
						dec.aluOp = aluSub;
						dec.resultSrc = resSlt;
					end
					3'b011: begin
						dec.aluOp = aluSubU;
						dec.resultSrc = resSlt;
					end
					3'b001, 3'b101: begin
						// Shamt comes from the immediate field
						dec.aluSrc = 1'b0;
						dec.immSrc = ext5;
						dec.resultSrc = resShift;
						if (funct7 == f7Base)
							dec.shiftOp = (funct3 == 3'b001) ? shLsl : shLsr;
						else if (funct7 == f7Alt && funct3 == 3'b101)
							dec.shiftOp = shAsr;
						else
							legal = 1'b0;
					end
					default: legal = 1'b0;
				endcase
			end
			opLoad: begin
				dec.regWrite = 1'b1;
				dec.aluOp = aluAdd; // Base plus offset
				dec.aluSrc = 1'b1;
				dec.immSrc = ext12;
				dec.resultSrc = resMem;
				case (funct3)
					3'b000: dec.memOp = memB;
					3'b001: dec.memOp = memH;
					3'b010: dec.memOp = memW;
					3'b100: dec.memOp = memBu;
					3'b101: dec.memOp = memHu;
					default: legal = 1'b0;
				endcase
			end
			opStore: begin
				dec.memWrite = 1'b1;
				dec.aluOp = aluAdd;
				dec.aluSrc = 1'b1;
				dec.immSrc = ext12;
				case (funct3)
					3'b000: dec.memOp = memB;
					3'b001: dec.memOp = memH;
					3'b010: dec.memOp = memW;
					default: legal = 1'b0;
				endcase
			end
			opBranch: begin
				dec.immSrc = ext12;
				dec.aluOp = funct3[1] ? aluSubU : aluSub; // Unsigned for bltu/bgeu
				case (funct3)
					3'b000: dec.branchOp = brEq;
					3'b001: dec.branchOp = brNe;
					3'b100: dec.branchOp = brLt;
					3'b101: dec.branchOp = brGe;
					3'b110: dec.branchOp = brLtu;
					3'b111: dec.branchOp = brGeu;
					default: legal = 1'b0;
				endcase
			end
			opJalr: begin
				dec.regWrite = 1'b1;
				dec.aluOp = aluAdd;
				dec.aluSrc = 1'b1;
				dec.immSrc = ext12;
				dec.resultSrc = resPcPlus4;
				dec.branchOp = brJalr;
				legal = (funct3 == 3'b000);
			end
			opJal: begin
				dec.regWrite = 1'b1;
				dec.immSrc = ext20;
				dec.resultSrc = resPcPlus4; // Link address
				dec.branchOp = brJal;
			end
			opAuipc: begin
				dec.regWrite = 1'b1;
				dec.immSrc = ext20;
				dec.resultSrc = resPcImm;
				dec.immSelect = 1'b1;
			end
			opLui: begin
				dec.regWrite = 1'b1;
				dec.aluSrc = 1'b1;
				dec.immSrc = ext20;
				dec.resultSrc = resImm;
				dec.immSelect = 1'b1;
			end
			default: legal = 1'b0;
		endcase
		if (!legal)
			dec = ctrlIdle;
	end

endmodule

//--- decoder/immGen.sv
`timescale 1ns/1ps

module immGen (
	input  ctrlPkg::instrU instr,
	output logic [19:0]    imm
);
	import ctrlPkg::*;

	logic [6:0] funct7;
	logic [2:0] funct3;

	assign funct7 = instr.rFmt.funct7;
	assign funct3 = instr.rFmt.funct3;

	always_comb begin
		imm = 20'b0;
		case (instr.rFmt.opcode)
			opImm: begin
				if (funct3 == 3'b001 || funct3 == 3'b101) begin
					if (funct7 == f7Base || (funct3 == 3'b101 && funct7 == f7Alt))
						imm = {15'b0, instr.rFmt.rs2}; // Shamt sits where rs2 would
				end else begin
					imm = {8'b0, instr.iFmt.imm};
				end
			end
			opLoad: begin
				if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101})
					imm = {8'b0, instr.iFmt.imm};
			end
			opJalr: begin
				if (funct3 == 3'b000)
					imm = {8'b0, instr.iFmt.imm};
			end
			opStore: begin
				if (funct3 inside {3'b000, 3'b001, 3'b010})
					imm = {8'b0, instr.sFmt.immHi, instr.sFmt.immLo};
			end
			opBranch: begin
				if (!(funct3 inside {3'b010, 3'b011}))
					imm = {7'b0, instr.bFmt.immSign, instr.bFmt.immBit11,
						instr.bFmt.immHi, instr.bFmt.immLo, 1'b0};
			end
			opJal: begin
				// Sign bit drops off the top
				imm = {instr.jFmt.immHi, instr.jFmt.immBit11, instr.jFmt.immLo, 1'b0};
			end
			opLui, opAuipc: imm = instr.uFmt.imm;
			default: imm = 20'b0;
		endcase
	end

endmodule

//--- decoder/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
	input  logic           clk,
	input  logic           rstN,
	input  ctrlPkg::instrU instr,
	input  logic           instrValid,
	output ctrlPkg::ctrlT  ctrl,
	output logic           ctrlValid
);
	import ctrlPkg::*;

	ctrlT        dec;
	logic [19:0] imm;
	ctrlT        merged;

	opDecoder i_opDecoder (
		.instr(instr),
		.dec  (dec)
	);

	immGen i_immGen (
		.instr(instr),
		.imm  (imm)
	);

	always_comb begin
		merged = dec;
		merged.imm = imm;
	end

	// Decode/execute pipeline register
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			ctrl <= ctrlIdle;
			ctrlValid <= 1'b0;
		end else begin
			ctrlValid <= instrValid;
			if (instrValid)
				ctrl <= merged;
			else
				ctrl <= ctrlIdle; // Bubble
		end
	end

endmodule

//--- source/branchResolver.sv
`timescale 1ns/1ps

module branchResolver (
	input  ctrlPkg::branchOpT branchOp,
	input  logic              valid,
	input  logic              zero,
	input  logic              negative,
	output ctrlPkg::pcSrcT    pcSrc
);
	import ctrlPkg::*;

	always_comb begin
		pcSrc = pcPlus4;
		if (valid) begin
			case (branchOp)
				brJal: pcSrc = pcTarget;
				brJalr: pcSrc = pcAluResult; // rs1 plus offset from ALU
				brEq: pcSrc = zero ? pcTarget : pcPlus4;
				brNe: pcSrc = zero ? pcPlus4 : pcTarget;
				brLt, brLtu: pcSrc = negative ? pcTarget : pcPlus4;
				brGe, brGeu: pcSrc = negative ? pcPlus4 : pcTarget;
				default: pcSrc = pcPlus4;
			endcase
		end
	end

endmodule

//--- source/controller.sv
`timescale 1ns/1ps

module controller (
	input  logic           clk,
	input  logic           rstN,
	input  ctrlPkg::instrU instr,
	input  logic           instrValid,
	input  logic           zero,      // From datapath, execute cycle
	input  logic           negative,
	output ctrlPkg::ctrlT  ctrl,
	output logic           ctrlValid,
	output ctrlPkg::pcSrcT pcSrc
);

	decodeStage i_decodeStage (
		.clk       (clk),
		.rstN      (rstN),
		.instr     (instr),
		.instrValid(instrValid),
		.ctrl      (ctrl),
		.ctrlValid (ctrlValid)
	);

	// Resolves in the same cycle as the registered word
	branchResolver i_branchResolver (
		.branchOp(ctrl.branchOp),
		.valid   (ctrlValid),
		.zero    (zero),
		.negative(negative),
		.pcSrc   (pcSrc)
	);

endmodule

//--- tests/controllerTb.sv
`timescale 1ns/1ps

module controllerTb;
	import ctrlPkg::*;

	localparam int clkPeriod = 20;
	localparam string patternFile = "tests/controllerPatterns.txt";
	localparam ctrlT idleWord = ctrlT'(43'h0000d000000); // aluMov, all else zero

	logic  clk;
	logic  rstN;
	instrU instr;
	logic  instrValid;
	logic  zero;
	logic  negative;
	ctrlT  ctrl;
	logic  ctrlValid;
	pcSrcT pcSrc;

	string       nameQ[$];
	logic [31:0] instrQ[$];
	logic        zeroQ[$];
	logic        negQ[$];
	ctrlT        ctrlQ[$];
	pcSrcT       pcQ[$];
	logic        loaded = 1'b0;
	integer      seed = 32'h4266;

	controller i_controller (
		.clk       (clk),
		.rstN      (rstN),
		.instr     (instr),
		.instrValid(instrValid),
		.zero      (zero),
		.negative  (negative),
		.ctrl      (ctrl),
		.ctrlValid (ctrlValid),
		.pcSrc     (pcSrc)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic checkCtrl(input string name, input ctrlT expected, input ctrlT actual);
		if (actual !== expected)
			abortRun($sformatf("mismatch %s ctrl: expected %h, actual %h",
				name, expected, actual));
	endtask

	task automatic checkPcSrc(input string name, input pcSrcT expected, input pcSrcT actual);
		if (actual !== expected)
			abortRun($sformatf("mismatch %s pcSrc: expected %0d, actual %0d",
				name, expected, actual));
	endtask

	task automatic checkValid(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			abortRun($sformatf("mismatch %s ctrlValid: expected %b, actual %b",
				name, expected, actual));
	endtask

	// Bubble or reset state
	task automatic checkIdle(input string name);
		checkValid(name, 1'b0, ctrlValid);
		checkCtrl(name, idleWord, ctrl);
		checkPcSrc(name, pcPlus4, pcSrc);
	endtask

	task automatic loadPatterns();
		integer fd;
		integer code;
		string  line;
		string  name;
		logic [31:0] instrWord;
		logic   zeroBit;
		logic   negBit;
		logic [$bits(ctrlT)-1:0] ctrlWord;
		integer pcWord;
		fd = $fopen(patternFile, "r");
		if (fd == 0)
			abortRun({"cannot open pattern file ", patternFile});
		while (!$feof(fd)) begin
			line = "";
			code = $fgets(line, fd);
			if (line.len() < 2 || line.substr(0, 1) == "//")
				continue; // Blank or comment
			code = $sscanf(line, "%s %h %b %b %h %d",
				name, instrWord, zeroBit, negBit, ctrlWord, pcWord);
			if (code != 6)
				abortRun({"malformed pattern line: ", line});
			nameQ.push_back(name);
			instrQ.push_back(instrWord);
			zeroQ.push_back(zeroBit);
			negQ.push_back(negBit);
			ctrlQ.push_back(ctrlT'(ctrlWord));
			pcQ.push_back(pcSrcT'(pcWord[1:0]));
		end
		$fclose(fd);
	endtask

	initial begin
		integer idle;
		integer i;
		rstN = 1'b0;
		instr = '0;
		instrValid = 1'b0;
		zero = 1'b0;
		negative = 1'b0;
		loadPatterns();
		loaded = 1'b1;
		repeat (10) @(posedge clk);
		#2 rstN = 1'b1;
		@(negedge clk);
		checkIdle("reset");
		for (i = 0; i < nameQ.size(); i++) begin
			idle = $unsigned($random(seed)) % 4;
			repeat (idle) begin
				@(posedge clk);
				#2 instrValid = 1'b0; // Old instr and flags stay on the bus
				@(negedge clk);
				checkIdle({nameQ[i], " idle"});
			end
			@(posedge clk);
			#2;
			instr = instrQ[i];
			instrValid = 1'b1;
			@(posedge clk);
			#2;
			instrValid = 1'b0;
			zero = zeroQ[i]; // Execute cycle flags
			negative = negQ[i];
			@(negedge clk);
			checkValid(nameQ[i], 1'b1, ctrlValid);
			checkCtrl(nameQ[i], ctrlQ[i], ctrl);
			checkPcSrc(nameQ[i], pcQ[i], pcSrc);
		end
		if (nameQ.size() == 0)
			abortRun("pattern file holds no patterns");
		else begin
			$display("** PASS **");
			$finish;
		end
	end

	// At most five cycles per pattern plus reset
	initial begin
		longint limitNs;
		wait (loaded);
		limitNs = (longint'(nameQ.size()) * 5 + 20) * clkPeriod;
		#(limitNs);
		abortRun("simulation timed out before all patterns ran");
	end

endmodule

//--- tests/controllerPatterns.txt
// name instr(hex) zero negative ctrl(ctrlT hex, 43 bits) pcSrc(0 plus4, 1 target, 2 aluResult)
// instructions use rd x1, rs1 x2, rs2 x3
add 003100b3 0 0 40004000000 0
sub 403100b3 1 0 40002000000 0
and 003170b3 0 1 40000000000 0
or 003160b3 1 1 4000c000000 0
xor 003140b3 0 0 40001000000 0
sll 003110b3 0 0 4410d000000 0
srl 003150b3 1 0 4450d000000 0
sra 403150b3 0 1 4490d000000 0
slt 003120b3 0 0 40182000000 0
sltu 003130b3 1 1 40189000000 0
addi ffb10093 0 0 51004000ffb 0
andi 0f017093 1 0 510000000f0 0
ori 12316093 0 1 5100c000123 0
xori 80014093 0 0 51001000800 0
slti 7ff12093 1 1 511820007ff 0
sltiu 00113093 0 0 51189000001 0
slli 00711093 0 0 4010d000007 0
srli 01f15093 1 0 4050d00001f 0
srai 40315093 0 1 4090d000003 0
lb 01010083 0 0 510c4000010 0
lh 01011083 1 0 510a4000010 0
lw ffc12083 0 1 51084000ffc 0
lbu 01014083 0 0 510b4000010 0
lhu 01015083 1 1 51094000010 0
sb 8a3102a3 0 0 310440008a5 0
sh 8a3112a3 1 0 310240008a5 0
sw 00312223 0 0 31004000004 0
beqTaken 00310863 1 0 01002100010 1
beqNotTaken fe310ce3 0 1 01002101ff8 0
bneTaken 00311863 0 0 01002200010 1
bneNotTaken 00311863 1 1 01002200010 0
bltTaken 00314863 0 1 01002300010 1
bltNotTaken 00314863 1 0 01002300010 0
bgeTaken fe315ce3 1 0 01002401ff8 1
bgeNotTaken 00315863 0 1 01002400010 0
bltuTaken 00316863 0 1 01009500010 1
bltuNotTaken 00316863 1 0 01009500010 0
bgeuTaken 00317863 0 0 01009600010 1
bgeuNotTaken 00317863 1 1 01009600010 0
jal b46120ef 0 0 4220d712346 1
jalr 004100e7 1 1 51204800004 2
lui abcde0b7 1 0 5a30d0abcde 0
auipc 12345097 0 1 4a28d012345 0
badOpcode 0000007f 1 1 0000d000000 0
badRtype 403170b3 1 0 0000d000000 0
badLoad 01013083 0 1 0000d000000 0

//--- flist.f
common/ctrlPkg.sv
decoder/opDecoder.sv
decoder/immGen.sv
decoder/decodeStage.sv
source/branchResolver.sv
source/controller.sv
tests/controllerTb.sv

//--- Bender.yml
package:
  name: controller

sources:
  - common/ctrlPkg.sv
  - decoder/opDecoder.sv
  - decoder/immGen.sv
  - decoder/decodeStage.sv
  - source/branchResolver.sv
  - source/controller.sv
  - target: test
    files:
      - tests/controllerTb.sv
